/* Bender.yml */
package:
  name: rv_fetch

sources:
  - fetch_pkg.sv
  - icache_array.sv
  - line_refill.sv
  - fetch_unit.sv
  - fetch_top.sv
  - target: simulation
    files:
      - tb_fetch_mem.sv
      - tb_fetch_top.sv

/* fetch_pkg.sv */
package fetch_pkg;

  // Line geometry of the instruction cache
  localparam int line_words = 4;
  localparam int offset_bits = 4;
  localparam int line_bits = 128;

  // Fetch control machine
  typedef enum logic [1:0] {
    fetch_lookup, // Look up the current pc
    fetch_refill, // Waiting for a line
    fetch_trap    // Fault reported, wait for redirect
  } fetch_state_e;

  // AXI4 read-burst master
  typedef enum logic [1:0] {
    refill_idle,
    refill_addr, // arvalid high
    refill_data  // rready high
  } refill_state_e;

endpackage

/* fetch_top.sv */
`timescale 1ns/1ps

module fetch_top #(
  parameter int          index_bits = 2,
  parameter logic [31:0] reset_pc = 32'h3000_0000
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        inst_ready,
  input  logic        redirect,
  input  logic [31:0] redirect_pc,
  input  logic        flush_icache,
  input  logic        arready,
  input  logic [31:0] rdata,
  input  logic [1:0]  rresp,
  input  logic        rvalid,
  input  logic        rlast,
  output logic        inst_valid,
  output logic [31:0] inst,
  output logic [31:0] inst_pc,
  output logic        fetch_misaligned,
  output logic        fetch_fault,
  output logic [31:0] fault_pc,
  output logic [31:0] araddr,
  output logic [7:0]  arlen,
  output logic        arvalid,
  output logic        rready
);
  import fetch_pkg::*;

  logic [31:0]          lookup_pc;
  logic                 hit;
  logic [31:0]          hit_word;
  logic                 cache_flush;
  logic                 refill_start;
  logic [31:0]          refill_pc;
  logic                 refill_done;
  logic                 refill_error;
  logic                 line_write;
  logic [31:0]          line_pc;
  logic [line_bits-1:0] line_data;

  fetch_unit #(
    .index_bits(index_bits),
    .reset_pc  (reset_pc)
  ) fetch_unit_i (
    .clock           (clock),
    .reset           (reset),
    .inst_ready      (inst_ready),
    .redirect        (redirect),
    .redirect_pc     (redirect_pc),
    .flush_icache    (flush_icache),
    .hit             (hit),
    .hit_word        (hit_word),
    .refill_done     (refill_done),
    .refill_error    (refill_error),
    .inst_valid      (inst_valid),
    .inst            (inst),
    .inst_pc         (inst_pc),
    .fetch_misaligned(fetch_misaligned),
    .fetch_fault     (fetch_fault),
    .fault_pc        (fault_pc),
    .lookup_pc       (lookup_pc),
    .cache_flush     (cache_flush),
    .refill_start    (refill_start),
    .refill_pc       (refill_pc)
  );

  icache_array #(
    .index_bits(index_bits)
  ) icache_array_i (
    .clock      (clock),
    .reset      (reset),
    .lookup_pc  (lookup_pc),
    .cache_flush(cache_flush),
    .line_write (line_write),
    .line_pc    (line_pc),
    .line_data  (line_data),
    .hit        (hit),
    .hit_word   (hit_word)
  );

  line_refill line_refill_i (
    .clock       (clock),
    .reset       (reset),
    .refill_start(refill_start),
    .refill_pc   (refill_pc),
    .arready     (arready),
    .rdata       (rdata),
    .rresp       (rresp),
    .rvalid      (rvalid),
    .rlast       (rlast),
    .araddr      (araddr),
    .arlen       (arlen),
    .arvalid     (arvalid),
    .rready      (rready),
    .line_data   (line_data),
    .line_pc     (line_pc),
    .line_write  (line_write),
    .refill_done (refill_done),
    .refill_error(refill_error)
  );

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
  parameter int          index_bits = 2,
  parameter logic [31:0] reset_pc = 32'h3000_0000
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        inst_ready,
  input  logic        redirect,
  input  logic [31:0] redirect_pc,
  input  logic        flush_icache,
  input  logic        hit,
  input  logic [31:0] hit_word,
  input  logic        refill_done,
  input  logic        refill_error,
  output logic        inst_valid,
  output logic [31:0] inst,
  output logic [31:0] inst_pc,
  output logic        fetch_misaligned,
  output logic        fetch_fault,
  output logic [31:0] fault_pc,
  output logic [31:0] lookup_pc,
  output logic        cache_flush,
  output logic        refill_start,
  output logic [31:0] refill_pc
);
  import fetch_pkg::*;

  localparam int tag_lsb = offset_bits + index_bits;

  fetch_state_e state;

  logic [31:0] pc;
  logic        refill_stale;
  logic        out_free;
  logic        misaligned;
  logic        do_lookup;
  logic        same_tag;
  logic        same_index;
  logic        same_line;

  assign lookup_pc = pc;
  assign refill_pc = pc;
  assign cache_flush = flush_icache;

  assign out_free = !inst_valid || inst_ready; // Output register empty or being taken
  assign misaligned = pc[1:0] != 2'b00;
  assign do_lookup = state == fetch_lookup && !redirect && out_free;
  assign refill_start = do_lookup && !misaligned && !hit;

  // A redirect inside the line being refilled still owns its bus result
  assign same_tag = redirect_pc[31:tag_lsb] == pc[31:tag_lsb];
  assign same_index = redirect_pc[tag_lsb-1:offset_bits] == pc[tag_lsb-1:offset_bits];
  assign same_line = same_tag && same_index && redirect_pc[1:0] == 2'b00;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= fetch_lookup;
      pc <= reset_pc;
      inst_valid <= 1'b0;
      fetch_misaligned <= 1'b0;
      fetch_fault <= 1'b0;
      refill_stale <= 1'b0;
    end else begin
      if (inst_valid && inst_ready) begin
        inst_valid <= 1'b0;
      end

      case (state)
        fetch_lookup: begin
          if (do_lookup) begin
            if (misaligned) begin
              fetch_misaligned <= 1'b1;
              state <= fetch_trap;
            end else if (hit) begin
              inst_valid <= 1'b1;
              pc <= pc + 32'd4;
            end else begin
              state <= fetch_refill;
            end
          end
        end
        fetch_refill: begin
          if (refill_done) begin
            refill_stale <= 1'b0;
            state <= fetch_lookup; // Next lookup hits the new line
          end else if (refill_error) begin
            refill_stale <= 1'b0;
            if (refill_stale || redirect) begin
              state <= fetch_lookup; // Error of an abandoned fetch
            end else begin
              fetch_fault <= 1'b1;
              state <= fetch_trap;
            end
          end
        end
        fetch_trap: begin
          // Held until redirect
        end
        default: begin
          state <= fetch_lookup;
        end
      endcase

      // Redirect overrides everything above
      if (redirect) begin
        pc <= redirect_pc;
        inst_valid <= 1'b0;
        fetch_misaligned <= 1'b0;
        fetch_fault <= 1'b0;
        if (state == fetch_trap) begin
          state <= fetch_lookup;
        end
        if (state == fetch_refill && !refill_done && !refill_error && !same_line) begin
          refill_stale <= 1'b1; // Burst finishes but feeds nothing
        end
      end
    end
  end

  // Payload registers
  always_ff @(posedge clock) begin
    if (do_lookup && !misaligned && hit) begin
      inst <= hit_word;
      inst_pc <= pc;
    end
    if (do_lookup && misaligned) begin
      fault_pc <= pc;
    end
    if (state == fetch_refill && refill_error) begin
      fault_pc <= pc;
    end
  end

endmodule

/* icache_array.sv */
`timescale 1ns/1ps

module icache_array #(
  parameter int index_bits = 2
) (
  input  logic                            clock,
  input  logic                            reset,
  input  logic [31:0]                     lookup_pc,
  input  logic                            cache_flush,
  input  logic                            line_write,
  input  logic [31:0]                     line_pc,
  input  logic [fetch_pkg::line_bits-1:0] line_data,
  output logic                            hit,
  output logic [31:0]                     hit_word
);
  import fetch_pkg::*;

  localparam int lines = 1 << index_bits;
  localparam int tag_lsb = offset_bits + index_bits;
  localparam int tag_bits = 32 - tag_lsb;
  localparam int word_sel_bits = $clog2(line_words);

  logic [lines-1:0]     valid_q;
  logic [tag_bits-1:0]  tag_mem [lines];
  logic [line_bits-1:0] data_mem [lines];

  logic [index_bits-1:0]    lookup_index;
  logic [tag_bits-1:0]      lookup_tag;
  logic [word_sel_bits-1:0] lookup_word;
  logic [index_bits-1:0]    write_index;
  logic [line_bits-1:0]     read_line;

  assign lookup_index = lookup_pc[tag_lsb-1:offset_bits];
  assign lookup_tag = lookup_pc[31:tag_lsb];
  assign lookup_word = lookup_pc[offset_bits-1 -: word_sel_bits]; // pc[3:2]
  assign write_index = line_pc[tag_lsb-1:offset_bits];

  // Hit path is purely combinational
  assign read_line = data_mem[lookup_index];
  assign hit = valid_q[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
  assign hit_word = read_line[lookup_word*32 +: 32];

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      if (cache_flush) begin
        valid_q <= '0;
      end
      if (line_write) begin
        valid_q[write_index] <= 1'b1; // Write beats a same-cycle flush
      end
    end
  end

  always_ff @(posedge clock) begin
    if (line_write) begin
      tag_mem[write_index] <= line_pc[31:tag_lsb];
      data_mem[write_index] <= line_data;
    end
  end

endmodule

/* line_refill.sv */
`timescale 1ns/1ps

module line_refill (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            refill_start,
  input  logic [31:0]                     refill_pc,
  input  logic                            arready,
  input  logic [31:0]                     rdata,
  input  logic [1:0]                      rresp,
  input  logic                            rvalid,
  input  logic                            rlast,
  output logic [31:0]                     araddr,
  output logic [7:0]                      arlen,
  output logic                            arvalid,
  output logic                            rready,
  output logic [fetch_pkg::line_bits-1:0] line_data,
  output logic [31:0]                     line_pc,
  output logic                            line_write,
  output logic                            refill_done,
  output logic                            refill_error
);
  import fetch_pkg::*;

  refill_state_e state;

  logic [line_bits-1:0] line_q;
  logic                 error_q;
  logic                 beat;
  logic                 beat_error;
  logic                 last_beat;
  logic                 burst_error;

  assign arlen = 8'(line_words - 1);
  assign line_pc = araddr;

  assign beat = rvalid && rready;
  assign beat_error = rresp != 2'b00;
  assign last_beat = beat && rlast;
  assign burst_error = error_q || beat_error;

  // Last beat goes straight into the array on the same edge
  assign line_data = {rdata, line_q[line_bits-1:32]};
  assign line_write = last_beat && !burst_error;
  assign refill_done = last_beat && !burst_error;
  assign refill_error = last_beat && burst_error;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= refill_idle;
      arvalid <= 1'b0;
      rready <= 1'b0;
      error_q <= 1'b0;
    end else begin
      case (state)
        refill_idle: begin
          if (refill_start) begin
            arvalid <= 1'b1;
            error_q <= 1'b0;
            state <= refill_addr;
          end
        end
        refill_addr: begin
          if (arready) begin // arvalid holds until accepted
            arvalid <= 1'b0;
            rready <= 1'b1;
            state <= refill_data;
          end
        end
        refill_data: begin
          if (beat) begin
            error_q <= burst_error; // Sticky over the burst
            if (rlast) begin
              rready <= 1'b0;
              state <= refill_idle;
            end
          end
        end
        default: begin
          state <= refill_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == refill_idle && refill_start) begin
      araddr <= {refill_pc[31:offset_bits], {offset_bits{1'b0}}}; // Line aligned
    end
    if (beat) begin
      line_q <= line_data; // Lowest word arrives first
    end
  end

endmodule

/* list.f */
fetch_pkg.sv
icache_array.sv
line_refill.sv
fetch_unit.sv
fetch_top.sv
tb_fetch_mem.sv
tb_fetch_top.sv

/* tb_fetch_mem.sv */
`timescale 1ns/1ps

module tb_fetch_mem (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] araddr,
  input  logic [7:0]  arlen,
  input  logic        arvalid,
  input  logic        rready,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  output logic        rlast
);

  logic [31:0] beat_addr;
  int          beats;

  function automatic logic [1:0] resp_for(input logic [31:0] a);
    return (a >= 32'h4000_0000 && a <= 32'h4000_00ff) ? 2'd2 : 2'd0; // SLVERR window
  endfunction

  // Random wait of 0 to 3 cycles, keeps the 1 ns drive offset
  task automatic stall_cycles();
    repeat ($urandom_range(0, 3)) begin
      @(posedge clock);
      #1;
    end
  endtask

  initial begin
    arready = 1'b0;
    rvalid = 1'b0;
    rlast = 1'b0;
    rdata = '0;
    rresp = 2'd0;
    forever begin
      @(posedge clock);
      if (!reset && arvalid) begin
        #1;
        stall_cycles();
        arready = 1'b1;
        @(posedge clock); // arvalid holds, so the address is taken here
        beat_addr = araddr;
        beats = arlen + 1;
        #1 arready = 1'b0;
        for (int i = 0; i < beats; i++) begin
          stall_cycles();
          rvalid = 1'b1;
          rdata = beat_addr ^ 32'h1357_9bdf;
          rresp = resp_for(beat_addr);
          rlast = i == beats - 1;
          @(posedge clock);
          while (!rready) @(posedge clock);
          #1 rvalid = 1'b0;
          rlast = 1'b0;
          beat_addr = beat_addr + 32'd4;
        end
      end
    end
  end

endmodule

/* tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;
  localparam int          index_bits = 2;
  localparam logic [31:0] reset_pc = 32'h3000_0000;
  localparam int          line_fills = 24;
  localparam int          insts_taken = 72;
  localparam int          watchdog_cycles = 4 * (line_fills * 32 + insts_taken * 4 + 300);

  logic        clock;
  logic        reset;
  logic        inst_ready;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic        flush_icache;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rlast;
  logic        inst_valid;
  logic [31:0] inst;
  logic [31:0] inst_pc;
  logic        fetch_misaligned;
  logic        fetch_fault;
  logic [31:0] fault_pc;
  logic [31:0] araddr;
  logic [7:0]  arlen;
  logic        arvalid;
  logic        rready;

  string       test_name = "reset";
  int          ar_count = 0;
  int unsigned seed;

  fetch_top #(
    .index_bits(index_bits),
    .reset_pc  (reset_pc)
  ) fetch_top_i (
    .clock           (clock),
    .reset           (reset),
    .inst_ready      (inst_ready),
    .redirect        (redirect),
    .redirect_pc     (redirect_pc),
    .flush_icache    (flush_icache),
    .arready         (arready),
    .rdata           (rdata),
    .rresp           (rresp),
    .rvalid          (rvalid),
    .rlast           (rlast),
    .inst_valid      (inst_valid),
    .inst            (inst),
    .inst_pc         (inst_pc),
    .fetch_misaligned(fetch_misaligned),
    .fetch_fault     (fetch_fault),
    .fault_pc        (fault_pc),
    .araddr          (araddr),
    .arlen           (arlen),
    .arvalid         (arvalid),
    .rready          (rready)
  );

  tb_fetch_mem tb_fetch_mem_i (
    .clock  (clock),
    .reset  (reset),
    .araddr (araddr),
    .arlen  (arlen),
    .arvalid(arvalid),
    .rready (rready),
    .arready(arready),
    .rdata  (rdata),
    .rresp  (rresp),
    .rvalid (rvalid),
    .rlast  (rlast)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("Timeout: tests did not finish within %0d cycles", watchdog_cycles);
    $display("Finished with errors");
    $fatal(1, "Watchdog expired");
  end

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return a ^ 32'h1357_9bdf;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
    $display("Finished with errors");
    $fatal(1, "Stopped at the first failing check");
  endtask

  always @(posedge clock) begin
    if (arvalid && arready) begin
      ar_count <= ar_count + 1;
      assert (arlen == 8'd3) else report_mismatch("arlen", 32'd3, {24'h0, arlen});
      assert (araddr[3:0] == 4'h0) else report_mismatch("araddr low bits", 32'h0, araddr);
    end
  end

  task automatic redirect_to(input logic [31:0] target);
    redirect = 1'b1;
    redirect_pc = target;
    @(posedge clock);
    #1 redirect = 1'b0;
  endtask

  task automatic expect_inst(input logic [31:0] expected_pc);
    inst_ready = 1'b1;
    @(posedge clock);
    while (!inst_valid) @(posedge clock);
    assert (inst_pc == expected_pc) else report_mismatch("inst_pc", expected_pc, inst_pc);
    assert (inst == mem_word(expected_pc))
      else report_mismatch("inst", mem_word(expected_pc), inst);
    #1;
  endtask

  task automatic expect_run(input logic [31:0] first, input int count);
    for (int i = 0; i < count; i++) begin
      expect_inst(first + 32'(4 * i));
    end
  endtask

  task automatic check_ar_count(input int start, input int expected);
    assert (ar_count - start == expected)
      else report_mismatch("AR handshakes", expected, ar_count - start);
  endtask

  // Stall decode and wait for a quiet bus
  task automatic settle_bus();
    int idle;
    idle = 0;
    inst_ready = 1'b0;
    while (idle < 4) begin
      @(posedge clock);
      idle = (arvalid || rready) ? 0 : idle + 1;
    end
    #1;
  endtask

  task automatic wait_for_trap(input logic bus_error);
    inst_ready = 1'b1;
    @(posedge clock);
    while (!(bus_error ? fetch_fault : fetch_misaligned)) begin
      assert (!inst_valid) else report_mismatch("inst_valid before trap", 32'h0, 32'h1);
      @(posedge clock);
    end
    #1;
  endtask

  task automatic sequential_fetch();
    int start;
    test_name = "sequential_fetch";
    start = ar_count;
    expect_run(reset_pc, 16);
    check_ar_count(start, 4);
    settle_bus();
  endtask

  task automatic back_pressure();
    logic [31:0] expected_pc;
    logic [31:0] held_inst;
    logic [31:0] held_pc;
    logic        held;
    test_name = "back_pressure";
    expected_pc = 32'h3000_1000;
    held = 1'b0;
    redirect_to(expected_pc);
    while (expected_pc != 32'h3000_1030) begin
      inst_ready = 1'($urandom_range(0, 1));
      @(posedge clock);
      if (held) begin
        assert (inst_valid) else report_mismatch("held inst_valid", 32'h1, 32'h0);
        assert (inst == held_inst) else report_mismatch("held inst", held_inst, inst);
        assert (inst_pc == held_pc) else report_mismatch("held inst_pc", held_pc, inst_pc);
      end
      held = inst_valid && !inst_ready;
      held_inst = inst;
      held_pc = inst_pc;
      if (inst_valid && inst_ready) begin
        assert (inst_pc == expected_pc) else report_mismatch("inst_pc", expected_pc, inst_pc);
        assert (inst == mem_word(expected_pc))
          else report_mismatch("inst", mem_word(expected_pc), inst);
        expected_pc = expected_pc + 32'd4;
      end
      #1;
    end
    settle_bus();
  endtask

  task automatic redirect_reuse();
    int start;
    test_name = "redirect_reuse";
    start = ar_count;
    redirect_to(32'h3000_1010); // Line already cached
    expect_run(32'h3000_1010, 4);
    settle_bus();
    check_ar_count(start, 0);
    start = ar_count;
    redirect_to(32'h3000_2000);
    expect_run(32'h3000_2000, 4);
    check_ar_count(start, 1);
    settle_bus();
  endtask

  task automatic flush_refetch();
    int start;
    test_name = "flush_refetch";
    start = ar_count;
    redirect_to(32'h3000_4000);
    expect_run(32'h3000_4000, 16);
    check_ar_count(start, 4);
    settle_bus();
    start = ar_count;
    flush_icache = 1'b1; // Same cycle as the redirect
    redirect_to(32'h3000_4000);
    flush_icache = 1'b0;
    expect_run(32'h3000_4000, 16);
    check_ar_count(start, 4);
    settle_bus();
  endtask

  task automatic misaligned_target();
    int start;
    test_name = "misaligned_target";
    start = ar_count;
    redirect_to(32'h3000_4002);
    wait_for_trap(1'b0);
    assert (fault_pc == 32'h3000_4002) else report_mismatch("fault_pc", 32'h3000_4002, fault_pc);
    repeat (16) begin
      @(posedge clock);
      assert (fetch_misaligned) else report_mismatch("fetch_misaligned", 32'h1, 32'h0);
      assert (!inst_valid) else report_mismatch("inst_valid in trap", 32'h0, 32'h1);
      assert (!fetch_fault) else report_mismatch("fetch_fault", 32'h0, 32'h1);
    end
    #1;
    check_ar_count(start, 0);
    redirect_to(32'h3000_4010);
    assert (!fetch_misaligned) else report_mismatch("fetch_misaligned cleared", 32'h0, 32'h1);
    expect_inst(32'h3000_4010);
    settle_bus();
  endtask

  task automatic bus_error();
    int start;
    test_name = "bus_error";
    start = ar_count;
    redirect_to(32'h4000_0048);
    wait_for_trap(1'b1);
    assert (fault_pc == 32'h4000_0048) else report_mismatch("fault_pc", 32'h4000_0048, fault_pc);
    assert (!fetch_misaligned) else report_mismatch("fetch_misaligned", 32'h0, 32'h1);
    check_ar_count(start, 1);
    redirect_to(32'h4000_0048); // Failed line must not be cached
    wait_for_trap(1'b1);
    assert (fault_pc == 32'h4000_0048) else report_mismatch("fault_pc", 32'h4000_0048, fault_pc);
    check_ar_count(start, 2);
    redirect_to(reset_pc);
    expect_inst(reset_pc);
    settle_bus();
  endtask

  initial begin
    seed = 32'h5eba_5d09;
    void'($urandom(seed));
    reset = 1'b1;
    inst_ready = 1'b0;
    redirect = 1'b0;
    redirect_pc = '0;
    flush_icache = 1'b0;
    repeat (3) @(posedge clock);
    #1 reset = 1'b0;
    assert (!inst_valid && !arvalid && !rready && !fetch_misaligned && !fetch_fault)
      else report_mismatch("outputs after reset", 32'h0,
                           {27'h0, inst_valid, arvalid, rready, fetch_misaligned, fetch_fault});
    sequential_fetch();
    back_pressure();
    redirect_reuse();
    flush_refetch();
    misaligned_target();
    bus_error();
    $display("Finished with no errors");
    $finish;
  end

endmodule
